//--- riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

`define XLEN       32
`define REG_ADDR_W 5

// Major opcodes of the supported 32-bit groups
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_SYSTEM 7'b1110011

// Machine-mode exception causes
`define CAUSE_ILLEGAL    4'd2
`define CAUSE_BREAKPOINT 4'd3
`define CAUSE_ECALL_M    4'd11

`endif

//--- riscv_pkg.sv
`include "riscv_defs.svh"

package riscv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } instr_full_t;

    typedef struct packed {
        logic [15:0]            upper;  // Unused by a 16-bit instruction
        logic [3:0]             funct4;
        logic [`REG_ADDR_W-1:0] rd_rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [1:0]             op;
    } instr_comp_t;

    typedef union packed {
        instr_full_t r;
        instr_comp_t c;
    } instr_word_t;

    typedef struct packed {
        logic                   valid;
        logic                   wren;
        logic                   rden1;
        logic                   rden2;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`REG_ADDR_W-1:0] raddr1;
        logic [`REG_ADDR_W-1:0] raddr2;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;
        logic                   use_pc;
        alu_op_t                alu_op;
        logic                   ebreak;
        logic                   ecall;
    } decode_ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       npc;
        instr_word_t            instr;
        logic                   wren;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       rdata1;
        logic [`XLEN-1:0]       rdata2;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;
        logic                   use_pc;
        alu_op_t                alu_op;
        logic                   exception;
        logic [3:0]             ecause;
    } decode_out_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       npc;
        instr_word_t            instr;
        logic                   wren;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       result;
        logic                   exception;
        logic [3:0]             ecause;
    } exec_out_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       npc;
        instr_word_t            instr;  // Also the exception value
        logic                   wren;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       wdata;
        logic                   exception;
        logic [3:0]             ecause;
    } retire_t;

endpackage

//--- instr_decoder.sv
`timescale 1ns/1ps
`include "riscv_defs.svh"

module instr_decoder (
    input  riscv_pkg::instr_word_t  instr,
    output riscv_pkg::decode_ctrl_t ctrl
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;

    assign imm_i = {{(`XLEN-12){instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
    assign imm_u = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.waddr  = instr.r.rd;
        ctrl.raddr1 = instr.r.rs1;
        ctrl.raddr2 = instr.r.rs2;
        ctrl.alu_op = riscv_pkg::ALU_ADD;
        case (instr.r.opcode)
            `OPC_OP_IMM: begin
                ctrl.valid   = 1'b1;
                ctrl.wren    = 1'b1;
                ctrl.rden1   = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = imm_i;
                case (instr.r.funct3)
                    3'b000: ctrl.alu_op = riscv_pkg::ALU_ADD;
                    3'b001: begin
                        ctrl.alu_op = riscv_pkg::ALU_SLL;
                        ctrl.valid  = (instr.r.funct7 == 7'b0000000);
                    end
                    3'b010: ctrl.alu_op = riscv_pkg::ALU_SLT;
                    3'b011: ctrl.alu_op = riscv_pkg::ALU_SLTU;
                    3'b100: ctrl.alu_op = riscv_pkg::ALU_XOR;
                    3'b101: begin
                        // Bit 30 picks the arithmetic shift
                        ctrl.alu_op = instr.r.funct7[5] ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
                        ctrl.valid  = ({instr.r.funct7[6], instr.r.funct7[4:0]} == 6'b0);
                    end
                    3'b110: ctrl.alu_op = riscv_pkg::ALU_OR;
                    default: ctrl.alu_op = riscv_pkg::ALU_AND;
                endcase
            end
            `OPC_OP: begin
                ctrl.valid = 1'b1;
                ctrl.wren  = 1'b1;
                ctrl.rden1 = 1'b1;
                ctrl.rden2 = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                    10'b0000000_000: ctrl.alu_op = riscv_pkg::ALU_ADD;
                    10'b0100000_000: ctrl.alu_op = riscv_pkg::ALU_SUB;
                    10'b0000000_001: ctrl.alu_op = riscv_pkg::ALU_SLL;
                    10'b0000000_010: ctrl.alu_op = riscv_pkg::ALU_SLT;
                    10'b0000000_011: ctrl.alu_op = riscv_pkg::ALU_SLTU;
                    10'b0000000_100: ctrl.alu_op = riscv_pkg::ALU_XOR;
                    10'b0000000_101: ctrl.alu_op = riscv_pkg::ALU_SRL;
                    10'b0100000_101: ctrl.alu_op = riscv_pkg::ALU_SRA;
                    10'b0000000_110: ctrl.alu_op = riscv_pkg::ALU_OR;
                    10'b0000000_111: ctrl.alu_op = riscv_pkg::ALU_AND;
                    default: ctrl.valid = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                ctrl.valid   = 1'b1;
                ctrl.wren    = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = imm_u;
                ctrl.alu_op  = riscv_pkg::ALU_PASS_B;
            end
            `OPC_AUIPC: begin
                ctrl.valid   = 1'b1;
                ctrl.wren    = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.use_pc  = 1'b1;
                ctrl.imm     = imm_u;
            end
            `OPC_SYSTEM: begin
                // Only ECALL and EBREAK are decoded and they need every other field zero
                if (instr.r.funct3 == 3'b000 && instr.r.rd == '0 && instr.r.rs1 == '0 &&
                    instr.r.funct7 == 7'b0000000) begin
                    ctrl.ecall  = (instr.r.rs2 == 5'd0);
                    ctrl.ebreak = (instr.r.rs2 == 5'd1);
                    ctrl.valid  = ctrl.ecall | ctrl.ebreak;
                end
            end
            default: ctrl.valid = 1'b0;
        endcase
    end

endmodule

//--- compress_decoder.sv
`timescale 1ns/1ps
`include "riscv_defs.svh"

module compress_decoder (
    input  riscv_pkg::instr_word_t  instr,
    output riscv_pkg::decode_ctrl_t ctrl
);

    logic [`XLEN-1:0] imm_ci;
    logic             rs2_zero;
    logic             rd_zero;

    // CI immediate is bit 12 over bits 6:2, which land in funct4[0] and rs2
    assign imm_ci   = {{(`XLEN-5){instr.c.funct4[0]}}, instr.c.rs2};
    assign rs2_zero = (instr.c.rs2 == '0);
    assign rd_zero  = (instr.c.rd_rs1 == '0);

    always_comb begin
        ctrl        = '0;
        ctrl.waddr  = instr.c.rd_rs1;
        ctrl.raddr1 = instr.c.rd_rs1;
        ctrl.raddr2 = instr.c.rs2;
        ctrl.alu_op = riscv_pkg::ALU_ADD;
        ctrl.imm    = imm_ci;
        case (instr.c.op)
            2'b01: begin
                ctrl.wren    = 1'b1;
                ctrl.rden1   = 1'b1;
                ctrl.use_imm = 1'b1;
                case (instr.c.funct4[3:1])
                    3'b000: ctrl.valid = 1'b1;  // C.ADDI
                    3'b010: begin
                        ctrl.raddr1 = '0;  // C.LI adds to x0
                        ctrl.valid  = 1'b1;
                    end
                    default: ctrl.valid = 1'b0;
                endcase
            end
            2'b10: begin
                if (instr.c.funct4 == 4'b1000 && !rs2_zero) begin
                    ctrl.valid  = 1'b1;  // C.MV
                    ctrl.wren   = 1'b1;
                    ctrl.rden1  = 1'b1;
                    ctrl.rden2  = 1'b1;
                    ctrl.raddr1 = '0;
                end else if (instr.c.funct4 == 4'b1001 && !rs2_zero) begin
                    ctrl.valid = 1'b1;  // C.ADD
                    ctrl.wren  = 1'b1;
                    ctrl.rden1 = 1'b1;
                    ctrl.rden2 = 1'b1;
                end else if (instr.c.funct4 == 4'b1001 && rd_zero) begin
                    ctrl.valid  = 1'b1;
                    ctrl.ebreak = 1'b1;
                end
            end
            default: ctrl.valid = 1'b0;
        endcase
    end

endmodule

//--- register_file.sv
`timescale 1ns/1ps
`include "riscv_defs.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    input  logic                   wren,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata
);

    logic [`XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wren && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Forwarding in decode covers the write in flight so reads need no write-through
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps
`include "riscv_defs.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [`XLEN-1:0]       pc,
    input  riscv_pkg::instr_word_t instr,
    output logic [`REG_ADDR_W-1:0] rf_raddr1,
    output logic [`REG_ADDR_W-1:0] rf_raddr2,
    input  logic [`XLEN-1:0]       rf_rdata1,
    input  logic [`XLEN-1:0]       rf_rdata2,
    input  riscv_pkg::exec_out_t   ex_fwd,
    input  riscv_pkg::exec_out_t   ex_reg,
    output riscv_pkg::decode_out_t q
);

    riscv_pkg::decode_ctrl_t ctrl_full;
    riscv_pkg::decode_ctrl_t ctrl_comp;
    riscv_pkg::decode_ctrl_t ctrl;
    riscv_pkg::decode_out_t  d;
    logic                    is_full;

    function automatic logic [`XLEN-1:0] fwd_operand(
        input logic                   rden,
        input logic [`REG_ADDR_W-1:0] raddr,
        input logic [`XLEN-1:0]       rf_data,
        input riscv_pkg::exec_out_t   near,
        input riscv_pkg::exec_out_t   far
    );
        logic want;
        want = rden && raddr != '0;
        if (want && near.valid && near.wren && near.waddr == raddr) begin
            return near.result;
        end else if (want && far.valid && far.wren && far.waddr == raddr) begin
            return far.result;
        end
        return rf_data;
    endfunction

    instr_decoder i_instr_decoder (
        .instr (instr),
        .ctrl  (ctrl_full)
    );

    compress_decoder i_compress_decoder (
        .instr (instr),
        .ctrl  (ctrl_comp)
    );

    assign is_full   = (instr.c.op == 2'b11);
    assign ctrl      = is_full ? ctrl_full : ctrl_comp;
    assign rf_raddr1 = ctrl.raddr1;
    assign rf_raddr2 = ctrl.raddr2;

    always_comb begin
        d         = '0;
        d.valid   = instr_valid;
        d.pc      = pc;
        d.npc     = pc + (is_full ? `XLEN'd4 : `XLEN'd2);
        d.instr   = instr;
        d.waddr   = ctrl.waddr;
        d.imm     = ctrl.imm;
        d.use_imm = ctrl.use_imm;
        d.use_pc  = ctrl.use_pc;
        d.alu_op  = ctrl.alu_op;
        d.rdata1  = fwd_operand(ctrl.rden1, ctrl.raddr1, rf_rdata1, ex_fwd, ex_reg);
        d.rdata2  = fwd_operand(ctrl.rden2, ctrl.raddr2, rf_rdata2, ex_fwd, ex_reg);
        if (!ctrl.valid) begin
            d.exception = 1'b1;
            d.ecause    = `CAUSE_ILLEGAL;
        end else if (ctrl.ebreak) begin
            d.exception = 1'b1;
            d.ecause    = `CAUSE_BREAKPOINT;
        end else if (ctrl.ecall) begin
            d.exception = 1'b1;
            d.ecause    = `CAUSE_ECALL_M;
        end
        d.wren      = instr_valid & ctrl.wren & ~d.exception;
        d.exception = instr_valid & d.exception;
    end

    always_ff @(posedge clk) begin
        q <= d;
        if (!rst) begin
            q.valid     <= 1'b0;
            q.wren      <= 1'b0;
            q.exception <= 1'b0;
        end
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps
`include "riscv_defs.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  riscv_pkg::decode_out_t d,
    output riscv_pkg::exec_out_t   y,
    output riscv_pkg::exec_out_t   q
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;

    assign op_a  = d.use_pc ? d.pc : d.rdata1;
    assign op_b  = d.use_imm ? d.imm : d.rdata2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (d.alu_op)
            riscv_pkg::ALU_ADD:    result = op_a + op_b;
            riscv_pkg::ALU_SUB:    result = op_a - op_b;
            riscv_pkg::ALU_SLL:    result = op_a << shamt;
            riscv_pkg::ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            riscv_pkg::ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            riscv_pkg::ALU_XOR:    result = op_a ^ op_b;
            riscv_pkg::ALU_SRL:    result = op_a >> shamt;
            riscv_pkg::ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            riscv_pkg::ALU_OR:     result = op_a | op_b;
            riscv_pkg::ALU_AND:    result = op_a & op_b;
            riscv_pkg::ALU_PASS_B: result = op_b;
            default:               result = '0;
        endcase
    end

    always_comb begin
        y.valid     = d.valid;
        y.pc        = d.pc;
        y.npc       = d.npc;
        y.instr     = d.instr;
        y.wren      = d.wren;
        y.waddr     = d.waddr;
        y.result    = result;
        y.exception = d.exception;
        y.ecause    = d.ecause;
    end

    always_ff @(posedge clk) begin
        q <= y;
        if (!rst) begin
            q.valid     <= 1'b0;
            q.wren      <= 1'b0;
            q.exception <= 1'b0;
        end
    end

endmodule

//--- retire_stage.sv
`timescale 1ns/1ps
`include "riscv_defs.svh"

module retire_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  riscv_pkg::exec_out_t   e,
    output logic                   rf_wren,
    output logic [`REG_ADDR_W-1:0] rf_waddr,
    output logic [`XLEN-1:0]       rf_wdata,
    output riscv_pkg::retire_t     retire
);

    // Writes to x0 are dropped here so the retire record shows no write
    assign rf_wren  = e.valid & e.wren & ~e.exception & (e.waddr != '0);
    assign rf_waddr = e.waddr;
    assign rf_wdata = e.result;

    always_ff @(posedge clk) begin
        if (!rst) begin
            retire.valid     <= 1'b0;
            retire.wren      <= 1'b0;
            retire.exception <= 1'b0;
        end else begin
            retire.valid     <= e.valid;
            retire.wren      <= rf_wren;
            retire.exception <= e.valid & e.exception;
        end
        retire.pc     <= e.pc;
        retire.npc    <= e.npc;
        retire.instr  <= e.instr;
        retire.waddr  <= e.waddr;
        retire.wdata  <= e.result;
        retire.ecause <= e.ecause;
    end

endmodule

//--- core_top.sv
`timescale 1ns/1ps
`include "riscv_defs.svh"

module core_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [`XLEN-1:0]       pc,
    input  riscv_pkg::instr_word_t instr,
    output riscv_pkg::retire_t     retire
);

    logic [`REG_ADDR_W-1:0] rf_raddr1;
    logic [`REG_ADDR_W-1:0] rf_raddr2;
    logic [`XLEN-1:0]       rf_rdata1;
    logic [`XLEN-1:0]       rf_rdata2;
    logic                   rf_wren;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`XLEN-1:0]       rf_wdata;
    riscv_pkg::decode_out_t dec_q;
    riscv_pkg::exec_out_t   ex_y;
    riscv_pkg::exec_out_t   ex_q;

    decode_stage i_decode_stage (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .pc          (pc),
        .instr       (instr),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .ex_fwd      (ex_y),
        .ex_reg      (ex_q),
        .q           (dec_q)
    );

    execute_stage i_execute_stage (
        .clk (clk),
        .rst (rst),
        .d   (dec_q),
        .y   (ex_y),
        .q   (ex_q)
    );

    retire_stage i_retire_stage (
        .clk      (clk),
        .rst      (rst),
        .e        (ex_q),
        .rf_wren  (rf_wren),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .retire   (retire)
    );

    register_file i_register_file (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wren   (rf_wren),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam real half_period = 2.0;  // 4 ns period

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

//--- core_tb.sv
`timescale 1ns/1ps
`include "riscv_defs.svh"

module core_tb;

    typedef struct packed {
        logic                   chain;  // Driven right after the previous row
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       instr;
        logic                   wren;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       wdata;
        logic [`XLEN-1:0]       npc;
        logic                   exc;
        logic [3:0]             ecause;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    logic [`XLEN-1:0]       pc;
    riscv_pkg::instr_word_t instr;
    riscv_pkg::retire_t     retire;

    row_t        rows[$];
    int          idle_q[$];
    row_t        exp_row[0:2];
    logic        exp_busy[0:2];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;
    int          idle_total;
    int unsigned rng_seed = 32'h9d0d;

    tb_clock_gen i_tb_clock_gen (
        .clk (clk)
    );

    core_top i_core_top (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .pc          (pc),
        .instr       (instr),
        .retire      (retire)
    );

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [19:0] imm,
                                           input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] c_type(input logic [3:0] f4, input logic [4:0] rd,
                                           input logic [4:0] rs2, input logic [1:0] op);
        return {16'h0000, f4, rd, rs2, op};
    endfunction

    task automatic add_row(input logic chain, input logic [31:0] row_pc,
                           input logic [31:0] word, input logic wren, input logic [4:0] waddr,
                           input logic [31:0] wdata, input logic [31:0] npc, input logic exc,
                           input logic [3:0] ecause);
        rows.push_back('{chain, row_pc, word, wren, waddr, wdata, npc, exc, ecause});
    endtask

    task automatic build_rows();
        add_row(0, 'h100, i_type(12'd5, 0, 3'b000, 1), 1, 1, 'h5, 'h104, 0, 0);
        add_row(1, 'h104, i_type(12'hffd, 1, 3'b000, 2), 1, 2, 'h2, 'h108, 0, 0);
        add_row(1, 'h108, r_type(7'h00, 2, 1, 3'b000, 3), 1, 3, 'h7, 'h10c, 0, 0);
        add_row(1, 'h10c, r_type(7'h20, 1, 3, 3'b000, 4), 1, 4, 'h2, 'h110, 0, 0);
        add_row(0, 'h110, i_type(12'hfff, 0, 3'b000, 5), 1, 5, 'hffffffff, 'h114, 0, 0);
        add_row(0, 'h114, r_type(7'h00, 1, 5, 3'b010, 6), 1, 6, 'h1, 'h118, 0, 0);
        add_row(0, 'h118, r_type(7'h00, 1, 5, 3'b011, 7), 1, 7, 'h0, 'h11c, 0, 0);
        add_row(0, 'h11c, i_type(12'h000, 5, 3'b010, 8), 1, 8, 'h1, 'h120, 0, 0);
        add_row(0, 'h120, i_type(12'hfff, 1, 3'b011, 9), 1, 9, 'h1, 'h124, 0, 0);
        add_row(0, 'h124, u_type(`OPC_LUI, 20'h80000, 11), 1, 11, 'h80000000, 'h128, 0, 0);
        add_row(0, 'h128, i_type(12'h404, 11, 3'b101, 10), 1, 10, 'hf8000000, 'h12c, 0, 0);
        add_row(0, 'h12c, i_type(12'h004, 11, 3'b101, 12), 1, 12, 'h08000000, 'h130, 0, 0);
        add_row(0, 'h130, i_type(12'h003, 1, 3'b001, 13), 1, 13, 'h28, 'h134, 0, 0);
        add_row(0, 'h134, r_type(7'h20, 1, 11, 3'b101, 14), 1, 14, 'hfc000000, 'h138, 0, 0);
        add_row(0, 'h138, i_type(12'hff0, 1, 3'b100, 15), 1, 15, 'hfffffff5, 'h13c, 0, 0);
        add_row(0, 'h13c, i_type(12'h008, 2, 3'b110, 16), 1, 16, 'ha, 'h140, 0, 0);
        add_row(0, 'h140, i_type(12'h0f0, 5, 3'b111, 17), 1, 17, 'hf0, 'h144, 0, 0);
        add_row(0, 'h144, u_type(`OPC_AUIPC, 20'h00001, 18), 1, 18, 'h1144, 'h148, 0, 0);
        add_row(0, 'h148, i_type(12'd7, 1, 3'b000, 0), 0, 0, 'h0, 'h14c, 0, 0);  // x0 write
        add_row(1, 'h14c, r_type(7'h00, 1, 0, 3'b000, 19), 1, 19, 'h5, 'h150, 0, 0);
        add_row(0, 'h150, c_type(4'b0101, 20, 5'b11110, 2'b01), 1, 20, 'hfffffffe, 'h152, 0, 0);
        add_row(1, 'h152, c_type(4'b0000, 20, 3, 2'b01), 1, 20, 'h1, 'h154, 0, 0);
        add_row(1, 'h154, c_type(4'b1000, 21, 20, 2'b10), 1, 21, 'h1, 'h156, 0, 0);
        add_row(0, 'h156, c_type(4'b1001, 21, 3, 2'b10), 1, 21, 'h8, 'h158, 0, 0);
        add_row(0, 'h158, 'h00000073, 0, 0, 0, 'h15c, 1, `CAUSE_ECALL_M);
        add_row(0, 'h15c, 'h00100073, 0, 0, 0, 'h160, 1, `CAUSE_BREAKPOINT);
        add_row(0, 'h160, c_type(4'b1001, 0, 0, 2'b10), 0, 0, 0, 'h162, 1, `CAUSE_BREAKPOINT);
        add_row(0, 'h162, 'h00000000, 0, 0, 0, 'h164, 1, `CAUSE_ILLEGAL);
        add_row(0, 'h164, 'h0000a183, 0, 0, 0, 'h168, 1, `CAUSE_ILLEGAL);  // LW x3
        add_row(0, 'h168, i_type(12'h041, 1, 3'b001, 4), 0, 0, 0, 'h16c, 1, `CAUSE_ILLEGAL);
        add_row(0, 'h16c, r_type(7'h00, 4, 3, 3'b000, 22), 1, 22, 'h9, 'h170, 0, 0);
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_retire(input logic busy, input row_t row);
        if (!busy) begin
            check_field("retire.valid", 32'd0, retire.valid);
        end else begin
            check_field("retire.valid", 32'd1, retire.valid);
            check_field("retire.pc", row.pc, retire.pc);
            check_field("retire.npc", row.npc, retire.npc);
            check_field("retire.instr", row.instr, retire.instr);
            check_field("retire.wren", row.wren, retire.wren);
            check_field("retire.exception", row.exc, retire.exception);
            if (row.wren) begin
                check_field("retire.waddr", row.waddr, retire.waddr);
                check_field("retire.wdata", row.wdata, retire.wdata);
            end
            if (row.exc) begin
                check_field("retire.ecause", row.ecause, retire.ecause);
            end
        end
    endtask

    // Checks the slot driven three falling edges ago and then drives the next one
    task automatic step(input logic busy, input row_t row);
        @(negedge clk);
        check_retire(exp_busy[2], exp_row[2]);
        exp_busy[2] = exp_busy[1];
        exp_row[2]  = exp_row[1];
        exp_busy[1] = exp_busy[0];
        exp_row[1]  = exp_row[0];
        exp_busy[0] = busy;
        exp_row[0]  = row;
        instr_valid = busy;
        pc          = row.pc;
        instr       = row.instr;
    endtask

    task automatic print_summary();
        $display("Checks: %0d, errors: %0d", checks, errors);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            print_summary();
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(rng_seed));
        rst         = 1'b0;
        instr_valid = 1'b0;
        pc          = '0;
        instr       = '0;
        for (int i = 0; i < 3; i++) begin
            exp_busy[i] = 1'b0;
            exp_row[i]  = '0;
        end
        build_rows();
        idle_total = 0;
        foreach (rows[i]) begin
            idle_q.push_back(rows[i].chain ? 0 : int'($urandom % 3));
            idle_total += idle_q[i];
        end
        limit = rows.size() + idle_total + 16 + 2 + 20;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        foreach (rows[i]) begin
            repeat (idle_q[i]) step(1'b0, '0);
            step(1'b1, rows[i]);
        end
        repeat (3) step(1'b0, '0);  // Drain the pipeline
        print_summary();
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
riscv_pkg.sv
instr_decoder.sv
compress_decoder.sv
register_file.sv
decode_stage.sv
execute_stage.sv
retire_stage.sv
core_top.sv
tb_clock_gen.sv
core_tb.sv
